// ==== hdl/bp_pkg.sv ====
// bp_pkg: address, index, counter types and fetch/resolve/prediction records of the predictor
`default_nettype none

`include "bp_settings.svh"

package bp_pkg;

    // plain vectors with a meaning
    typedef logic [`BP_ADDR_W-1:0] addr_t;                 // pc or target
    typedef logic [`BP_BTB_IDX_W-1:0] btb_idx_t;           // pc bits just above bit 1
    typedef logic [`BP_ADDR_W-`BP_BTB_TAG_LSB-1:0] btb_tag_t; // pc bits above the index
    typedef logic [1:0] ctr_t;                             // 2 or 3 means taken

    // fetch side, one per cycle
    typedef struct packed {
        addr_t current_pc;
        logic  is_jalr;    // predecode flag
    } fetch_req_t;

    // execute side, one per resolved control transfer
    typedef struct packed {
        logic  valid;
        addr_t pc;         // pc of the resolved instruction
        addr_t target;     // resolved target
        logic  taken;
        logic  is_branch;  // conditional branch
        logic  is_jump;    // jal or jalr
        logic  is_call;    // jal/jalr writing the link register
        logic  is_return;  // jalr reading link, not writing it
    } resolve_t;

    // answer back to fetch, same cycle
    typedef struct packed {
        logic  predict_taken;
        addr_t target_addr;
    } prediction_t;

endpackage

`default_nettype wire

// ==== hdl/bp_settings.svh ====
// bp settings: sizing of the next-PC predictor (address width, BTB and return stack)
`ifndef BP_SETTINGS_SVH
`define BP_SETTINGS_SVH

// pc width, RV32
`define BP_ADDR_W 32

// direct-mapped BTB
`define BP_BTB_ENTRIES 16 // power of two
`define BP_BTB_IDX_W 4    // log2 of BP_BTB_ENTRIES

// return address stack
`define BP_RAS_DEPTH 4    // power of two
`define BP_RAS_PTR_W 2    // log2 of BP_RAS_DEPTH

// pc bits 1:0 sit below the index, the tag takes the rest
`define BP_BTB_TAG_LSB (`BP_BTB_IDX_W + 2)

`endif

// ==== hdl/branch_predictor_wrapper.sv ====
// branch_predictor_wrapper: next-PC predictor top, BTB for most fetches, return stack for JALR
`timescale 1ns/10ps
`default_nettype none

module branch_predictor_wrapper (
    input  wire logic               CLK,
    input  wire logic               rst_n,
    input  wire bp_pkg::fetch_req_t fetch,      // from fetch, every cycle
    input  wire bp_pkg::resolve_t   resolve,    // from execute
    output bp_pkg::prediction_t     prediction  // back to fetch, same cycle
);

    // answers of the two predictors
    bp_pkg::prediction_t btb_pred;
    bp_pkg::prediction_t ras_pred;

    // direction and target for branches and jumps
    btb_predictor btb (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .fetch      (fetch),
        .resolve    (resolve),   // trains on branches and jumps
        .prediction (btb_pred)
    );

    // return targets
    return_predictor ras (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .fetch      (fetch),
        .resolve    (resolve),   // calls push, returns pop
        .prediction (ras_pred)
    );

    // predecode flag picks the source
    // a JALR is treated as a return here, its target is not in the BTB reliably
    always_comb begin
        if (fetch.is_jalr) begin
            prediction = ras_pred;
        end else begin
            prediction = btb_pred;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/btb_predictor.sv ====
// btb_predictor: direct-mapped branch target buffer with two-bit direction counters
`timescale 1ns/10ps
`default_nettype none

`include "bp_settings.svh"

module btb_predictor (
    input  wire logic               CLK,
    input  wire logic               rst_n,
    input  wire bp_pkg::fetch_req_t fetch,
    input  wire bp_pkg::resolve_t   resolve,
    output bp_pkg::prediction_t     prediction
);

    // per entry storage
    logic [`BP_BTB_ENTRIES-1:0] valid_q;                  // only control state, reset below
    bp_pkg::btb_tag_t           tag_q    [`BP_BTB_ENTRIES];
    bp_pkg::addr_t              target_q [`BP_BTB_ENTRIES];
    bp_pkg::ctr_t               ctr_q    [`BP_BTB_ENTRIES];

    // lookup side
    bp_pkg::btb_idx_t lkp_idx;
    bp_pkg::btb_tag_t lkp_tag;
    logic             lkp_hit;

    // training side
    bp_pkg::btb_idx_t upd_idx;
    bp_pkg::btb_tag_t upd_tag;
    logic             upd_en;
    logic             upd_hit;
    logic             entry_wr;  // tag and counter written
    logic             target_wr; // target written too
    bp_pkg::ctr_t     ctr_cur;
    bp_pkg::ctr_t     ctr_nxt;

    // split the pcs into index and tag
    assign lkp_idx = fetch.current_pc[`BP_BTB_TAG_LSB-1:2];
    assign lkp_tag = fetch.current_pc[`BP_ADDR_W-1:`BP_BTB_TAG_LSB];
    assign upd_idx = resolve.pc[`BP_BTB_TAG_LSB-1:2];
    assign upd_tag = resolve.pc[`BP_ADDR_W-1:`BP_BTB_TAG_LSB];

    // lookup reads registered state only, so a same-cycle update is not visible yet
    assign lkp_hit = valid_q[lkp_idx] && (tag_q[lkp_idx] == lkp_tag);

    always_comb begin
        prediction.predict_taken = lkp_hit && ctr_q[lkp_idx][1]; // msb set means 2 or 3
        prediction.target_addr   = '0;
        if (prediction.predict_taken) begin
            prediction.target_addr = target_q[lkp_idx];
        end
    end

    // returns belong to the stack, not the BTB
    assign upd_en  = resolve.valid && (resolve.is_branch || resolve.is_jump)
                     && !resolve.is_return;
    assign upd_hit = valid_q[upd_idx] && (tag_q[upd_idx] == upd_tag);
    assign ctr_cur = ctr_q[upd_idx];

    // counter update
    always_comb begin
        ctr_nxt = ctr_cur;
        if (!upd_hit) begin
            ctr_nxt = 2'd2;                 // fresh entry, weakly taken
        end else if (resolve.is_jump) begin
            ctr_nxt = 2'd3;                 // jumps always go
        end else if (resolve.taken) begin
            if (ctr_cur != 2'd3) begin
                ctr_nxt = ctr_cur + 2'd1;   // saturate up
            end
        end else if (ctr_cur != 2'd0) begin
            ctr_nxt = ctr_cur - 2'd1;       // saturate down
        end
    end

    // a miss that was not taken leaves the entry alone
    assign entry_wr  = upd_en && (upd_hit || resolve.taken);
    assign target_wr = entry_wr && resolve.taken;

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0; // all entries invalid
        end else if (entry_wr) begin
            valid_q[upd_idx] <= 1'b1;
        end
    end

    // payload, meaningless while the valid bit is low
    always_ff @(posedge CLK) begin
        if (entry_wr) begin
            tag_q[upd_idx] <= upd_tag;   // same tag on a hit, new owner on allocation
            ctr_q[upd_idx] <= ctr_nxt;
        end
        if (target_wr) begin
            target_q[upd_idx] <= resolve.target;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/return_predictor.sv ====
// return_predictor: circular return address stack, push on call, pop on return
`timescale 1ns/10ps
`default_nettype none

`include "bp_settings.svh"

module return_predictor (
    input  wire logic               CLK,
    input  wire logic               rst_n,
    input  wire bp_pkg::fetch_req_t fetch,
    input  wire bp_pkg::resolve_t   resolve,
    output bp_pkg::prediction_t     prediction
);

    // occupancy saturates here
    localparam logic [`BP_RAS_PTR_W:0] RAS_FULL = (`BP_RAS_PTR_W + 1)'(`BP_RAS_DEPTH);

    bp_pkg::addr_t             stack_q [`BP_RAS_DEPTH]; // return addresses
    logic [`BP_RAS_PTR_W-1:0]  top_q;                   // slot of the newest entry
    logic [`BP_RAS_PTR_W:0]    count_q;                 // 0..DEPTH valid entries

    logic                      do_pop;
    logic                      do_push;
    logic [`BP_RAS_PTR_W-1:0]  top_pop;   // after the pop step
    logic [`BP_RAS_PTR_W:0]    count_pop;
    logic [`BP_RAS_PTR_W-1:0]  top_nxt;   // after the push step
    logic [`BP_RAS_PTR_W:0]    count_nxt;
    bp_pkg::addr_t             link_addr;

    // only JALR fetches consume the stack
    always_comb begin
        prediction.predict_taken = fetch.is_jalr && (count_q != '0);
        prediction.target_addr   = '0;
        if (prediction.predict_taken) begin
            prediction.target_addr = stack_q[top_q];
        end
    end

    assign do_pop  = resolve.valid && resolve.is_return && (count_q != '0); // empty pop ignored
    assign do_push = resolve.valid && resolve.is_call;
    assign link_addr = resolve.pc + bp_pkg::addr_t'(4); // no rv32c, always pc + 4

    // pop first, then push, so a call+return record replaces the top
    always_comb begin
        top_pop   = top_q;
        count_pop = count_q;
        if (do_pop) begin
            top_pop   = top_q - 1'b1;
            count_pop = count_q - 1'b1;
        end
        top_nxt   = top_pop;
        count_nxt = count_pop;
        if (do_push) begin
            top_nxt = top_pop + 1'b1;       // wraps onto the oldest slot when full
            if (count_pop != RAS_FULL) begin
                count_nxt = count_pop + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            top_q   <= '0;
            count_q <= '0; // empty stack
        end else begin
            top_q   <= top_nxt;
            count_q <= count_nxt;
        end
    end

    // stack slots carry payload only
    always_ff @(posedge CLK) begin
        if (do_push) begin
            stack_q[top_nxt] <= link_addr;
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, and grep the output for the pass message
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module tb_branch_predictor -Mdir obj_dir -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -q "All tests passed!" &&
echo "simulation PASS" ||
{ echo "simulation FAIL"; exit 1; }

// ==== sources.f ====
+incdir+hdl
hdl/bp_pkg.sv
hdl/btb_predictor.sv
hdl/return_predictor.sv
hdl/branch_predictor_wrapper.sv
testbench/tb_branch_predictor.sv

// ==== testbench/tb_branch_predictor.sv ====
// tb_branch_predictor: table and random checks of the next-PC predictor against a behavioral model
`timescale 1ns/10ps
`default_nettype none

`include "bp_settings.svh"

module tb_branch_predictor;

    localparam int CLK_PERIOD = 100; // ns
    localparam int DRIVE_SKEW = 5;   // inputs change this long after the edge
    localparam int N_RANDOM   = 200;

    // resolve record kinds
    localparam logic [2:0] K_NONE     = 3'd0;
    localparam logic [2:0] K_BRANCH   = 3'd1;
    localparam logic [2:0] K_JUMP     = 3'd2;
    localparam logic [2:0] K_CALL     = 3'd3;
    localparam logic [2:0] K_RETURN   = 3'd4;
    localparam logic [2:0] K_CALL_RET = 3'd5;

    localparam bp_pkg::addr_t PC_A  = 32'h0000_1008; // index 2
    localparam bp_pkg::addr_t PC_B  = 32'h0000_2008; // index 2 too, other tag
    localparam bp_pkg::addr_t TGT_A = 32'h0000_1100;
    localparam bp_pkg::addr_t TGT_B = 32'h0000_2200;
    localparam bp_pkg::addr_t PC_R  = 32'h0000_4000; // the jalr being predicted

    typedef struct {
        string               name;
        bp_pkg::fetch_req_t  fetch;
        bp_pkg::resolve_t    resolve;
        bp_pkg::prediction_t expected;
    } step_t;

    logic                CLK;
    logic                rst_n;
    bp_pkg::fetch_req_t  fetch;
    bp_pkg::resolve_t    resolve;
    bp_pkg::prediction_t prediction;

    step_t       steps[$];  // directed table
    logic [31:0] lcg_state;

    // reference model state
    logic [`BP_BTB_ENTRIES-1:0] m_valid;
    bp_pkg::btb_tag_t           m_tag    [`BP_BTB_ENTRIES];
    bp_pkg::addr_t              m_target [`BP_BTB_ENTRIES];
    bp_pkg::ctr_t               m_ctr    [`BP_BTB_ENTRIES];
    bp_pkg::addr_t              m_stack[$]; // newest at the back

    // small pc pool, several share index 0 or 2
    bp_pkg::addr_t pc_pool [8] = '{32'h1000, 32'h1004, 32'h1008, 32'h2008,
                                   32'h3008, 32'h100c, 32'h2000, 32'h4040};

    branch_predictor_wrapper dut (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .fetch      (fetch),
        .resolve    (resolve),
        .prediction (prediction)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 15; // low bits of an lcg repeat quickly
    endfunction

    function automatic bp_pkg::resolve_t make_record(input logic [2:0] kind,
                                                     input bp_pkg::addr_t pc,
                                                     input bp_pkg::addr_t target,
                                                     input logic taken);
        bp_pkg::resolve_t r;
        r           = '0;
        r.valid     = (kind != K_NONE);
        r.pc        = pc;
        r.target    = target;
        r.is_branch = (kind == K_BRANCH);
        r.is_call   = (kind == K_CALL) || (kind == K_CALL_RET);
        r.is_return = (kind == K_RETURN) || (kind == K_CALL_RET);
        r.is_jump   = (kind == K_JUMP) || r.is_call || r.is_return; // calls and returns jump too
        r.taken     = r.is_jump || (r.is_branch && taken);
        return r;
    endfunction

    function automatic void add_step(input string name, input bp_pkg::addr_t pc,
                                     input logic jalr, input bp_pkg::resolve_t rec,
                                     input logic exp_taken, input bp_pkg::addr_t exp_target);
        step_t s;
        s.name                    = name;
        s.fetch.current_pc        = pc;
        s.fetch.is_jalr           = jalr;
        s.resolve                 = rec;
        s.expected.predict_taken  = exp_taken;
        s.expected.target_addr    = exp_target;
        steps.push_back(s);
    endfunction

    function automatic bp_pkg::prediction_t model_predict(input bp_pkg::fetch_req_t f);
        bp_pkg::prediction_t p;
        bp_pkg::btb_idx_t    idx;
        bp_pkg::btb_tag_t    tag;
        p   = '0;
        idx = bp_pkg::btb_idx_t'(f.current_pc >> 2);
        tag = bp_pkg::btb_tag_t'(f.current_pc >> (`BP_BTB_IDX_W + 2));
        if (f.is_jalr) begin
            if (m_stack.size() > 0) begin
                p.predict_taken = 1'b1;
                p.target_addr   = m_stack[$];
            end
        end else if (m_valid[idx] && m_tag[idx] == tag && m_ctr[idx] >= 2'd2) begin
            p.predict_taken = 1'b1;
            p.target_addr   = m_target[idx];
        end
        return p;
    endfunction

    function automatic void model_update(input bp_pkg::resolve_t r);
        bp_pkg::btb_idx_t idx;
        bp_pkg::btb_tag_t tag;
        logic             hit;
        idx = bp_pkg::btb_idx_t'(r.pc >> 2);
        tag = bp_pkg::btb_tag_t'(r.pc >> (`BP_BTB_IDX_W + 2));
        hit = m_valid[idx] && (m_tag[idx] == tag);
        if (r.valid && (r.is_branch || r.is_jump) && !r.is_return) begin
            if (hit) begin
                if (r.is_jump) begin
                    m_ctr[idx] = 2'd3;
                end else if (r.taken && m_ctr[idx] != 2'd3) begin
                    m_ctr[idx] = m_ctr[idx] + 2'd1;
                end else if (!r.taken && m_ctr[idx] != 2'd0) begin
                    m_ctr[idx] = m_ctr[idx] - 2'd1;
                end
                if (r.taken) begin
                    m_target[idx] = r.target;
                end
            end else if (r.taken) begin
                m_valid[idx]  = 1'b1; // allocate, old owner gone
                m_tag[idx]    = tag;
                m_target[idx] = r.target;
                m_ctr[idx]    = 2'd2;
            end
        end
        if (r.valid && r.is_return && m_stack.size() > 0) begin
            void'(m_stack.pop_back());  // pop comes before the push
        end
        if (r.valid && r.is_call) begin
            m_stack.push_back(r.pc + 32'd4);
            if (m_stack.size() > `BP_RAS_DEPTH) begin
                void'(m_stack.pop_front()); // oldest lost
            end
        end
    endfunction

    function automatic void build_table();
        bp_pkg::resolve_t none;
        bp_pkg::resolve_t a_t;
        bp_pkg::resolve_t a_nt;
        bp_pkg::resolve_t ret;
        none = make_record(K_NONE, '0, '0, 1'b0);
        a_t  = make_record(K_BRANCH, PC_A, TGT_A, 1'b1);
        a_nt = make_record(K_BRANCH, PC_A, TGT_A, 1'b0);
        ret  = make_record(K_RETURN, PC_R, 32'h0, 1'b1);
        // empty after reset
        add_step("reset_btb", PC_A, 1'b0, none, 1'b0, '0);
        add_step("reset_jalr", PC_R, 1'b1, none, 1'b0, '0);
        // allocation and counter walk, lookup sees the old entry in the update cycle
        add_step("train_a", PC_A, 1'b0, a_t, 1'b0, '0);
        add_step("a_hit", PC_A, 1'b0, a_t, 1'b1, TGT_A);
        add_step("a_strong", PC_A, 1'b0, a_nt, 1'b1, TGT_A);
        add_step("a_weak", PC_A, 1'b0, a_nt, 1'b1, TGT_A);
        add_step("a_not_taken", PC_A, 1'b0, a_nt, 1'b0, '0);
        add_step("a_floor", PC_A, 1'b0, a_nt, 1'b0, '0);  // counter stuck at 0, not wrapped
        add_step("a_held", PC_A, 1'b0, a_t, 1'b0, '0);    // a wrapped counter shows taken here
        add_step("a_rising", PC_A, 1'b0, a_t, 1'b0, '0);
        add_step("a_back", PC_A, 1'b0, none, 1'b1, TGT_A);
        // alias on index 2
        add_step("alias_miss", PC_B, 1'b0, none, 1'b0, '0);
        add_step("alias_train", PC_B, 1'b0, make_record(K_BRANCH, PC_B, TGT_B, 1'b1), 1'b0, '0);
        add_step("alias_hit", PC_B, 1'b0, none, 1'b1, TGT_B);
        add_step("a_evicted", PC_A, 1'b0, none, 1'b0, '0);
        // two calls, two returns
        add_step("call1", PC_R, 1'b1, make_record(K_CALL, 32'h3000, 32'h0, 1'b1), 1'b0, '0);
        add_step("call2", PC_R, 1'b1, make_record(K_CALL, 32'h3100, 32'h0, 1'b1), 1'b1, 32'h3004);
        add_step("ret_top", PC_R, 1'b1, ret, 1'b1, 32'h3104);
        add_step("ret_prev", PC_R, 1'b1, ret, 1'b1, 32'h3004);
        add_step("ras_empty", PC_R, 1'b1, none, 1'b0, '0);
        add_step("ras_empty_pop", PC_R, 1'b1, ret, 1'b0, '0);
        // overflow, five calls into four slots
        add_step("fill1", PC_R, 1'b1, make_record(K_CALL, 32'h5000, 32'h0, 1'b1), 1'b0, '0);
        add_step("fill2", PC_R, 1'b1, make_record(K_CALL, 32'h5100, 32'h0, 1'b1), 1'b1, 32'h5004);
        add_step("fill3", PC_R, 1'b1, make_record(K_CALL, 32'h5200, 32'h0, 1'b1), 1'b1, 32'h5104);
        add_step("fill4", PC_R, 1'b1, make_record(K_CALL, 32'h5300, 32'h0, 1'b1), 1'b1, 32'h5204);
        add_step("fill5", PC_R, 1'b1, make_record(K_CALL, 32'h5400, 32'h0, 1'b1), 1'b1, 32'h5304);
        add_step("pop1", PC_R, 1'b1, ret, 1'b1, 32'h5404);
        add_step("pop2", PC_R, 1'b1, ret, 1'b1, 32'h5304);
        add_step("pop3", PC_R, 1'b1, ret, 1'b1, 32'h5204);
        add_step("pop4", PC_R, 1'b1, ret, 1'b1, 32'h5104);
        add_step("ras_drained", PC_R, 1'b1, none, 1'b0, '0);
        // call and return in one record, pop on empty is skipped, push stays
        add_step("call_ret", PC_R, 1'b1, make_record(K_CALL_RET, 32'h6000, 32'h0, 1'b1), 1'b0, '0);
        add_step("call_ret_top", PC_R, 1'b1, none, 1'b1, 32'h6004);
    endfunction

    task automatic check_prediction(input string name, input bp_pkg::prediction_t exp);
        assert (prediction === exp) else begin
            $display("ERR %s: expected taken=%0b target=%h, actual taken=%0b target=%h",
                     name, exp.predict_taken, exp.target_addr,
                     prediction.predict_taken, prediction.target_addr);
            $display("Test failures found");
            $fatal(1, "prediction mismatch");
        end
    endtask

    // drive after the edge, sample just before the next one, then step the model
    task automatic run_step(input step_t s);
        @(posedge CLK);
        #(DRIVE_SKEW);
        fetch   = s.fetch;
        resolve = s.resolve;
        #(CLK_PERIOD - DRIVE_SKEW - 1);
        check_prediction(s.name, s.expected);
        model_update(s.resolve);
    endtask

    initial begin
        step_t       s;
        logic [31:0] r;
        logic [2:0]  kind;
        lcg_state = 32'd38;
        rst_n     = 1'b0;
        fetch     = '0;
        resolve   = '0;
        m_valid   = '0;
        m_stack.delete();
        build_table();
        repeat (8) @(posedge CLK);
        #(DRIVE_SKEW);
        rst_n = 1'b1;
        foreach (steps[i]) begin
            run_step(steps[i]);
        end
        for (int i = 0; i < N_RANDOM; i++) begin
            r    = lcg_next();
            kind = (r[7:5] > K_CALL_RET) ? K_BRANCH : r[7:5]; // extra weight on branches
            s.name               = $sformatf("random_%0d", i);
            s.fetch.current_pc   = pc_pool[r[2:0]];
            s.fetch.is_jalr      = r[3] & r[4];
            // half the records train the pc being looked up
            s.resolve  = make_record(kind, r[8] ? s.fetch.current_pc : pc_pool[r[11:9]],
                                     pc_pool[r[14:12]] + 32'h100, r[15]);
            s.expected = model_predict(s.fetch);
            run_step(s);
        end
        @(posedge CLK);
        $display("All tests passed!");
        $finish;
    end

    // watchdog
    initial begin
        #1;
        #((steps.size() + N_RANDOM + 20) * CLK_PERIOD);
        $display("watchdog: the run did not finish in time");
        $display("Test failures found");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire
